/* rcc_clk_pkg.sv */
// clock source numbering and switch constants for the rtc kernel clock
// selector codes double as the switch input index
// SEL_W must cover CLK_NUM inputs

package rcc_clk_pkg;

  // ==================================================
  // switch geometry
  // ==================================================

  // none, lse, lsi, hse
  localparam int CLK_NUM = 4;

  // selector width, 2**SEL_W >= CLK_NUM
  localparam int SEL_W = 2;

  // ==================================================
  // rtcsel encodings
  // ==================================================

  // input 0, no functional clock (test_clk only under scan)
  localparam logic [SEL_W-1:0] RTCSEL_NONE = 2'd0;
  // low-speed external oscillator
  localparam logic [SEL_W-1:0] RTCSEL_LSE  = 2'd1;
  // low-speed internal oscillator
  localparam logic [SEL_W-1:0] RTCSEL_LSI  = 2'd2;
  // high-speed external, already divided for rtc
  localparam logic [SEL_W-1:0] RTCSEL_HSE  = 2'd3;

  // ==================================================
  // handover timing
  // ==================================================

  // falling-edge stages per source enable, at least 2
  localparam int SW_SYNC_STAGES = 2;

endpackage

/* rcc_rst_pkg.sv */
// reset conventions for the vsw domain
// all resets here are active low and asserted asynchronously

package rcc_rst_pkg;

  // ==================================================
  // synchronizer depth
  // ==================================================

  // flops per reset synchronizer, at least 2
  localparam int RST_SYNC_STAGES = 2;

  // ==================================================
  // polarity
  // ==================================================

  // level of an asserted reset
  localparam logic RST_ASSERT_LVL  = 1'b0;
  // level of a released reset
  localparam logic RST_RELEASE_LVL = 1'b1;

endpackage

/* rcc_reset_sync.sv */
`timescale 1ns/1ns
// async assert, sync release reset synchronizer
// release lands on the STAGE_NUM-th rising clk edge, STAGE_NUM >= 2
// clk must be running for the release to propagate
// under testmode the output is the raw input so scan owns every reset

module rcc_reset_sync #(
  parameter int STAGE_NUM = rcc_rst_pkg::RST_SYNC_STAGES
) (
  input  logic src_rst_n,
  input  logic clk,
  input  logic testmode,
  output logic gen_rst_n
);

  // shift chain, stage 0 samples the release level first
  logic [STAGE_NUM-1:0] sync_q;

  // ==================================================
  // release chain
  // ==================================================

  // cleared at once when the source reset asserts
  // then walks the release level through the chain
  always_ff @(posedge clk or negedge src_rst_n) begin
    if (!src_rst_n) begin
      sync_q <= {STAGE_NUM{rcc_rst_pkg::RST_ASSERT_LVL}};
    end else begin
      sync_q <= {sync_q[STAGE_NUM-2:0], rcc_rst_pkg::RST_RELEASE_LVL};
    end
  end

  // ==================================================
  // output select
  // ==================================================

  // last stage drives the domain
  // testmode hands the raw reset straight through
  assign gen_rst_n = testmode ? src_rst_n : sync_q[STAGE_NUM-1];

endmodule

/* glitch_free_clk_switch.sv */
`timescale 1ns/1ns
// glitch-free N-input clock switch, one-hot enables handed over on falling edges
// each source needs its own clock running to drop or gain its enable
// a failed or reset source never gains enable, output then stays low
// testmode moves the enable flops to rising edges for scan, not glitch-free then
// sel must be able to code every input, 2**SEL_W >= CLK_NUM

module glitch_free_clk_switch #(
  parameter int CLK_NUM = rcc_clk_pkg::CLK_NUM
) (
  input  logic [CLK_NUM-1:0]            i_clk,
  input  logic [CLK_NUM-1:0]            clk_fail,
  input  logic [rcc_clk_pkg::SEL_W-1:0] sel,
  input  logic [CLK_NUM-1:0]            rst_n,
  input  logic                          testmode,
  input  logic                          scan_mode,
  input  logic                          test_clk,
  output logic                          o_clk
);

  // per-source request before synchronization
  logic [CLK_NUM-1:0] clk_req;
  // per-source enable, last stage of each chain
  logic [CLK_NUM-1:0] clk_en;
  // some other source still owns the output
  logic [CLK_NUM-1:0] others_en;
  // clock seen by each enable chain
  logic [CLK_NUM-1:0] sync_clk;
  // each source clock after its own enable
  logic [CLK_NUM-1:0] gated_clk;
  // functional mux result before the scan override
  logic               func_clk;

  // ==================================================
  // per-source request and enable chain
  // ==================================================

  for (genvar i = 0; i < CLK_NUM; i++) begin : g_src

    // enable chain, stage 0 samples the request
    logic [rcc_clk_pkg::SW_SYNC_STAGES-1:0] sync_q;

    // any enable except this source's own
    assign others_en[i] = |(clk_en & ~((CLK_NUM)'(1) << i));

    // request needs selection, a healthy source and an idle output
    // the idle term is what serializes the handover
    // old enable must be fully low before the new chain starts
    assign clk_req[i] = (sel == (rcc_clk_pkg::SEL_W)'(i)) &
                        ~clk_fail[i] &
                        ~others_en[i];

    // functional chain runs on falling edges of the source
    // inverting the clock keeps the flops rising-edge for synthesis
    // scan wants all flops on the same edge, so no inversion in testmode
    assign sync_clk[i] = testmode ? i_clk[i] : ~i_clk[i];

    // reset in the source's own domain
    // a source held in reset keeps its enable low
    always_ff @(posedge sync_clk[i] or negedge rst_n[i]) begin
      if (!rst_n[i]) begin
        sync_q <= '0;
      end else begin
        sync_q <= {sync_q[rcc_clk_pkg::SW_SYNC_STAGES-2:0], clk_req[i]};
      end
    end

    // enable changes only while the source clock is low
    assign clk_en[i] = sync_q[rcc_clk_pkg::SW_SYNC_STAGES-1];

    // and gate is safe, enable never moves during the high phase
    assign gated_clk[i] = i_clk[i] & clk_en[i];

  end

  // ==================================================
  // output combine
  // ==================================================

  // at most one enable is high, so OR acts as the mux
  // between sources every term is low and so is the output
  assign func_clk = |gated_clk;

  // scan takes the output directly
  assign o_clk = scan_mode ? test_clk : func_clk;

endmodule

/* en_as_clk_gating.sv */
`timescale 1ns/1ns
// latch-based clock gate, enable captured while raw_clk is low
// bypass forces the gate open for test
// reset closes the gate and pulls the output low at once

module en_as_clk_gating (
  input  logic raw_clk,
  input  logic active,
  input  logic bypass,
  input  logic rst_n,
  output logic gen_clk
);

  // enable as seen by the and gate
  logic en_lat;

  // ==================================================
  // low-phase enable latch
  // ==================================================

  // transparent only while raw_clk is low
  // a change of active during the high phase waits for the next low phase
  // so no pulse is ever cut short
  always_latch begin
    if (!rst_n) begin
      en_lat <= 1'b0;
    end else if (!raw_clk) begin
      en_lat <= active | bypass;
    end
  end

  // ==================================================
  // gate
  // ==================================================

  // latched enable is stable across the high phase
  assign gen_clk = raw_clk & en_lat;

endmodule

/* rcc_vsw_clk_rst_ctrl.sv */
`timescale 1ns/1ns
// vsw domain clock and reset control for the rtc kernel clock
// arst_n and bdrst are combined without synchronization, both asynchronous
// kernel reset release needs the selected source clock to run
// testmode and scan_mode are static levels, not changed during function

module rcc_vsw_clk_rst_ctrl (
  // test controls
  input  logic                          testmode,
  input  logic                          test_rst_n,
  input  logic                          test_clk,
  input  logic                          scan_mode,
  // reset requests
  input  logic                          arst_n,
  input  logic                          bdrst,
  // source clocks
  input  logic                          hse_rtc_clk,
  input  logic                          lsi_clk,
  input  logic                          lse_clk,
  // lse failure from clock security
  input  logic                          lsecss_fail,
  // kernel clock control
  input  logic                          rtcen,
  input  logic [rcc_clk_pkg::SEL_W-1:0] rtcsel,
  // outputs
  output logic                          rcc_rtc_ker_clk,
  output logic                          vsw_rst_n,
  output logic                          rtc_clk_sync_vsw_rst_n
);

  // functional reset before the test mux
  logic                            func_vsw_rst_n;
  // resets synced into each source domain
  logic                            hse_rtc_sync_vsw_rst_n;
  logic                            lsi_sync_vsw_rst_n;
  logic                            lse_sync_vsw_rst_n;
  // switch inputs, indexed by rtcsel code
  logic [rcc_clk_pkg::CLK_NUM-1:0] sw_clk;
  logic [rcc_clk_pkg::CLK_NUM-1:0] sw_fail;
  logic [rcc_clk_pkg::CLK_NUM-1:0] sw_rst_n;
  // switched clock before the gate
  logic                            rcc_rtcsel_clk;

  // ==================================================
  // vsw reset
  // ==================================================

  // power reset or backup-domain reset
  assign func_vsw_rst_n = arst_n & ~bdrst;

  // testmode hands the domain reset to the tester
  assign vsw_rst_n = testmode ? test_rst_n : func_vsw_rst_n;

  // ==================================================
  // reset synchronizers
  // ==================================================

  // one per source domain
  rcc_reset_sync #(
    .STAGE_NUM(rcc_rst_pkg::RST_SYNC_STAGES)
  ) u_hse_rtc_vsw_rst_sync (
    .src_rst_n(vsw_rst_n),
    .clk      (hse_rtc_clk),
    .testmode (testmode),
    .gen_rst_n(hse_rtc_sync_vsw_rst_n)
  );

  rcc_reset_sync #(
    .STAGE_NUM(rcc_rst_pkg::RST_SYNC_STAGES)
  ) u_lsi_vsw_rst_sync (
    .src_rst_n(vsw_rst_n),
    .clk      (lsi_clk),
    .testmode (testmode),
    .gen_rst_n(lsi_sync_vsw_rst_n)
  );

  rcc_reset_sync #(
    .STAGE_NUM(rcc_rst_pkg::RST_SYNC_STAGES)
  ) u_lse_vsw_rst_sync (
    .src_rst_n(vsw_rst_n),
    .clk      (lse_clk),
    .testmode (testmode),
    .gen_rst_n(lse_sync_vsw_rst_n)
  );

  // kernel side, released only once the switched clock runs
  rcc_reset_sync #(
    .STAGE_NUM(rcc_rst_pkg::RST_SYNC_STAGES)
  ) u_rtc_clk_sync_vsw_rst_sync (
    .src_rst_n(vsw_rst_n),
    .clk      (rcc_rtcsel_clk),
    .testmode (testmode),
    .gen_rst_n(rtc_clk_sync_vsw_rst_n)
  );

  // ==================================================
  // switch inputs
  // ==================================================

  // input 0 carries test_clk under scan, else a flat low
  assign sw_clk[rcc_clk_pkg::RTCSEL_NONE] = scan_mode & test_clk;
  assign sw_clk[rcc_clk_pkg::RTCSEL_LSE]  = lse_clk;
  assign sw_clk[rcc_clk_pkg::RTCSEL_LSI]  = lsi_clk;
  assign sw_clk[rcc_clk_pkg::RTCSEL_HSE]  = hse_rtc_clk;

  // input 0 never wins functionally
  assign sw_fail[rcc_clk_pkg::RTCSEL_NONE] = 1'b1;
  assign sw_fail[rcc_clk_pkg::RTCSEL_LSE]  = lsecss_fail;
  assign sw_fail[rcc_clk_pkg::RTCSEL_LSI]  = 1'b0;
  assign sw_fail[rcc_clk_pkg::RTCSEL_HSE]  = 1'b0;

  // input 0 follows the kernel-side reset
  assign sw_rst_n[rcc_clk_pkg::RTCSEL_NONE] = rtc_clk_sync_vsw_rst_n;
  assign sw_rst_n[rcc_clk_pkg::RTCSEL_LSE]  = lse_sync_vsw_rst_n;
  assign sw_rst_n[rcc_clk_pkg::RTCSEL_LSI]  = lsi_sync_vsw_rst_n;
  assign sw_rst_n[rcc_clk_pkg::RTCSEL_HSE]  = hse_rtc_sync_vsw_rst_n;

  // ==================================================
  // kernel clock
  // ==================================================

  glitch_free_clk_switch #(
    .CLK_NUM(rcc_clk_pkg::CLK_NUM)
  ) u_rcc_rtc_clk_switch (
    .i_clk    (sw_clk),
    .clk_fail (sw_fail),
    .sel      (rtcsel),
    .rst_n    (sw_rst_n),
    .testmode (testmode),
    .scan_mode(scan_mode),
    .test_clk (test_clk),
    .o_clk    (rcc_rtcsel_clk)
  );

  // rtcen gate, open under testmode
  en_as_clk_gating u_rtc_ker_clk_gating (
    .raw_clk(rcc_rtcsel_clk),
    .active (rtcen),
    .bypass (testmode),
    .rst_n  (rtc_clk_sync_vsw_rst_n),
    .gen_clk(rcc_rtc_ker_clk)
  );

endmodule

/* rcc_vsw_assertions.sv */
`timescale 1ns/1ns
// concurrent checks bound into the rtc kernel clock and vsw reset top
// sampled on falling test_clk, which sits between all source clock edges
// fail_count is read back by the testbench at the end of the run

module rcc_vsw_assertions (
  input logic                            test_clk,
  input logic                            testmode,
  input logic                            scan_mode,
  input logic                            vsw_rst_n,
  input logic                            rtc_clk_sync_vsw_rst_n,
  input logic                            rcc_rtc_ker_clk,
  input logic [rcc_clk_pkg::CLK_NUM-1:0] sw_en
);

  int fail_count = 0;

  // ==================================================
  // reset ordering
  // ==================================================

  // kernel reset never ahead of the domain reset
  kernel_rst_order_a: assert property (@(negedge test_clk)
    !vsw_rst_n |-> !rtc_clk_sync_vsw_rst_n)
    else begin
      fail_count++;
      $error("rtc_clk_sync_vsw_rst_n high while vsw_rst_n is low");
    end

  // functional release waits for RST_SYNC_STAGES kernel edges
  kernel_rst_lag_a: assert property (@(negedge test_clk)
    (!testmode && $rose(vsw_rst_n)) |-> !rtc_clk_sync_vsw_rst_n)
    else begin
      fail_count++;
      $error("rtc_clk_sync_vsw_rst_n released together with vsw_rst_n");
    end

  // ==================================================
  // kernel clock
  // ==================================================

  // gate stays closed in kernel reset
  ker_clk_in_reset_a: assert property (@(negedge test_clk)
    !rtc_clk_sync_vsw_rst_n |-> !rcc_rtc_ker_clk)
    else begin
      fail_count++;
      $error("kernel clock high while rtc_clk_sync_vsw_rst_n is low");
    end

  // handover is break-before-make
  sw_en_onehot_a: assert property (@(negedge test_clk) disable iff (scan_mode)
    $onehot0(sw_en))
    else begin
      fail_count++;
      $error("two clock switch enables high together: %b", sw_en);
    end

endmodule

/* tb_rcc_vsw_clk_rst_ctrl.sv */
`timescale 1ns/1ns
// trace-driven testbench for the rtc kernel clock and vsw reset control
// each trace step is applied on a rising hse edge and settles before measuring
// kernel period is timed from rising edges polled off the 10 ns clock-edge grid
// run from the project root so the trace path resolves

module tb_rcc_vsw_clk_rst_ctrl;

  // ==================================================
  // clocks, windows and trace
  // ==================================================

  localparam int HSE_PERIOD  = 40;
  localparam int LSI_PERIOD  = 120;
  localparam int LSE_PERIOD  = 280;
  localparam int TEST_PERIOD = 40;
  // test_clk edges land between the source edges
  localparam int TEST_PHASE  = 10;
  localparam int SLOW_PERIOD = LSE_PERIOD;
  localparam int SETTLE_NS   = 12 * SLOW_PERIOD;
  // own timeout of each edge wait
  localparam int EDGE_TIMEOUT_NS = 2 * SLOW_PERIOD;
  // poll grid never meets a clock edge
  localparam int POLL_STEP   = 5;
  localparam int POLL_PHASE  = 2;
  localparam int RST_CYCLES  = 2;
  localparam string TRACE_FILE = "rcc_vsw_trace.txt";

  // dut inputs
  logic                          testmode;
  logic                          test_rst_n;
  logic                          test_clk;
  logic                          scan_mode;
  logic                          arst_n;
  logic                          bdrst;
  logic                          hse_rtc_clk;
  logic                          lsi_clk;
  logic                          lse_clk;
  logic                          lsecss_fail;
  logic                          rtcen;
  logic [rcc_clk_pkg::SEL_W-1:0] rtcsel;
  // dut outputs
  logic                          rcc_rtc_ker_clk;
  logic                          vsw_rst_n;
  logic                          rtc_clk_sync_vsw_rst_n;

  int period_errors;
  int level_errors;
  int other_errors;
  int assert_errors;
  int step_count;

  // free-running sources
  always #(HSE_PERIOD/2) hse_rtc_clk = ~hse_rtc_clk;
  always #(LSI_PERIOD/2) lsi_clk = ~lsi_clk;
  always #(LSE_PERIOD/2) lse_clk = ~lse_clk;

  // same period as hse, shifted by TEST_PHASE
  always begin
    #(TEST_PHASE) test_clk = ~test_clk;
    #(TEST_PERIOD/2 - TEST_PHASE);
  end

  rcc_vsw_clk_rst_ctrl dut_i (
    .testmode              (testmode),
    .test_rst_n            (test_rst_n),
    .test_clk              (test_clk),
    .scan_mode             (scan_mode),
    .arst_n                (arst_n),
    .bdrst                 (bdrst),
    .hse_rtc_clk           (hse_rtc_clk),
    .lsi_clk               (lsi_clk),
    .lse_clk               (lse_clk),
    .lsecss_fail           (lsecss_fail),
    .rtcen                 (rtcen),
    .rtcsel                (rtcsel),
    .rcc_rtc_ker_clk       (rcc_rtc_ker_clk),
    .vsw_rst_n             (vsw_rst_n),
    .rtc_clk_sync_vsw_rst_n(rtc_clk_sync_vsw_rst_n)
  );

  bind rcc_vsw_clk_rst_ctrl rcc_vsw_assertions assertions_i (
    .test_clk              (test_clk),
    .testmode              (testmode),
    .scan_mode             (scan_mode),
    .vsw_rst_n             (vsw_rst_n),
    .rtc_clk_sync_vsw_rst_n(rtc_clk_sync_vsw_rst_n),
    .rcc_rtc_ker_clk       (rcc_rtc_ker_clk),
    .sw_en                 (u_rcc_rtc_clk_switch.clk_en)
  );

  // ==================================================
  // compare tasks
  // ==================================================

  task automatic check_period(input string name, input int expected, input int actual);
    if (actual !== expected) begin
      period_errors++;
      $display("CHECK FAILED %s period: expected %0d ns, actual %0d ns",
               name, expected, actual);
    end
  endtask

  task automatic check_level(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      level_errors++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  // ==================================================
  // kernel clock measurement
  // ==================================================

  // seen stays 0 when the timeout runs out
  task automatic wait_ker_rise(output bit seen, output time stamp);
    logic prev;
    int   waited;
    seen   = 1'b0;
    stamp  = 0;
    waited = 0;
    prev   = rcc_rtc_ker_clk;
    while (!seen && waited < EDGE_TIMEOUT_NS) begin
      #(POLL_STEP);
      waited += POLL_STEP;
      if (prev !== 1'b1 && rcc_rtc_ker_clk === 1'b1) begin
        seen  = 1'b1;
        stamp = $time;
      end
      prev = rcc_rtc_ker_clk;
    end
  endtask

  // period between two rising edges, 0 if fewer than two show up
  task automatic measure_period(output int period_ns);
    bit  first_seen;
    bit  second_seen;
    time first_stamp;
    time second_stamp;
    period_ns = 0;
    wait_ker_rise(first_seen, first_stamp);
    if (first_seen) begin
      wait_ker_rise(second_seen, second_stamp);
      if (second_seen) begin
        period_ns = int'(second_stamp - first_stamp);
      end
    end
  endtask

  // ==================================================
  // trace steps
  // ==================================================

  task automatic run_trace();
    int    fd;
    int    n;
    int    measured;
    int    col [10];
    string line;
    string step_name;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      other_errors++;
      $display("could not open %s, no steps were run", TRACE_FILE);
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) == 0) begin
        break;
      end
      // comments and blank lines
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d", col[0], col[1], col[2],
                  col[3], col[4], col[5], col[6], col[7], col[8], col[9]);
      if (n != 10) begin
        other_errors++;
        $display("trace line has %0d fields instead of 10: %s", n, line);
        continue;
      end
      step_count++;
      step_name = $sformatf("step %0d", step_count);
      @(posedge hse_rtc_clk);
      testmode    <= (col[0] != 0);
      scan_mode   <= (col[1] != 0);
      test_rst_n  <= (col[2] != 0);
      bdrst       <= (col[3] != 0);
      lsecss_fail <= (col[4] != 0);
      rtcen       <= (col[5] != 0);
      rtcsel      <= (rcc_clk_pkg::SEL_W)'(col[6]);
      // handover and reset release, then onto the poll grid
      #(SETTLE_NS + POLL_PHASE);
      check_level({step_name, " vsw_rst_n"}, (col[8] != 0), vsw_rst_n);
      check_level({step_name, " rtc_clk_sync_vsw_rst_n"}, (col[9] != 0),
                  rtc_clk_sync_vsw_rst_n);
      measure_period(measured);
      check_period(step_name, col[7], measured);
    end
    $fclose(fd);
  endtask

  // ==================================================
  // main sequence
  // ==================================================

  initial begin
    period_errors = 0;
    level_errors  = 0;
    other_errors  = 0;
    assert_errors = 0;
    step_count    = 0;
    hse_rtc_clk   = 1'b0;
    lsi_clk       = 1'b0;
    lse_clk       = 1'b0;
    test_clk      = 1'b0;
    testmode      = 1'b0;
    scan_mode     = 1'b0;
    test_rst_n    = 1'b1;
    bdrst         = 1'b0;
    lsecss_fail   = 1'b0;
    rtcen         = 1'b0;
    rtcsel        = rcc_clk_pkg::RTCSEL_NONE;
    arst_n        = 1'b0;

    // both resets low while arst_n is held
    @(posedge hse_rtc_clk);
    #(POLL_PHASE);
    check_level("reset hold vsw_rst_n", 1'b0, vsw_rst_n);
    check_level("reset hold rtc_clk_sync_vsw_rst_n", 1'b0, rtc_clk_sync_vsw_rst_n);
    repeat (RST_CYCLES - 1) @(posedge hse_rtc_clk);
    arst_n <= 1'b1;

    run_trace();
    if (step_count == 0) begin
      other_errors++;
      $display("no steps were read from %s", TRACE_FILE);
    end
    assert_errors = dut_i.assertions_i.fail_count;

    $display("errors: period %0d, level %0d, assertion %0d, other %0d over %0d steps",
             period_errors, level_errors, assert_errors, other_errors, step_count);
    if (period_errors + level_errors + assert_errors + other_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* rcc_vsw_trace.txt */
# testmode scan_mode test_rst_n bdrst lsecss_fail rtcen rtcsel(0 none 1 lse 2 lsi 3 hse)
# then expected kernel_period_ns (0 = no edges) vsw_rst_n rtc_clk_sync_vsw_rst_n
0 0 1 0 0 1 3 40 1 1
0 0 1 0 0 1 2 120 1 1
0 0 1 0 0 1 1 280 1 1
0 0 1 0 0 1 3 40 1 1
0 0 1 0 0 1 0 0 1 1
0 0 1 0 0 0 3 0 1 1
0 0 1 0 0 0 2 0 1 1
0 0 1 0 0 0 1 0 1 1
0 0 1 0 0 1 1 280 1 1
0 0 1 0 1 1 1 0 1 1
0 0 1 0 1 1 3 40 1 1
0 0 1 0 1 1 1 0 1 1
0 0 1 0 0 1 1 280 1 1
0 0 1 1 0 1 1 0 0 0
0 0 1 0 0 1 3 40 1 1
0 0 1 1 0 1 0 0 0 0
0 0 1 0 0 1 0 0 1 0
0 0 1 0 0 1 2 120 1 1
1 0 0 1 0 1 2 0 0 0
1 0 1 1 0 1 2 120 1 1
1 1 1 1 0 1 2 40 1 1
1 1 1 0 0 1 0 40 1 1
1 1 1 0 0 0 3 40 1 1
1 1 0 0 0 1 3 0 0 0
0 0 1 0 0 1 3 40 1 1

/* compile.f */
rcc_clk_pkg.sv
rcc_rst_pkg.sv
rcc_reset_sync.sv
glitch_free_clk_switch.sv
en_as_clk_gating.sv
rcc_vsw_clk_rst_ctrl.sv
rcc_vsw_assertions.sv
tb_rcc_vsw_clk_rst_ctrl.sv
